/* hdl/gnn_feature_pkg.sv */
package gnn_feature_pkg;

    // ==============================
    // datapath sizes
    // ==============================
    localparam int fv_size      = 8;
    localparam int max_fv_num   = 16;
    localparam int fv_per_line  = 4;
    localparam int num_pe       = 4;
    localparam int mult_per_pe  = 4;
    localparam int max_node_id  = 64;
    localparam int node_id_w    = $clog2(max_node_id);
    localparam int acc_w        = 20;
    localparam int fv_idx_w     = $clog2(max_fv_num);
    localparam int slot_w       = $clog2(num_pe);
    localparam int line_w       = $clog2(max_fv_num / fv_per_line);
    localparam int chunk_w      = $clog2(max_fv_num / mult_per_pe);
    localparam int result_depth = 8;
    localparam int result_ptr_w = $clog2(result_depth);
    localparam int occ_w        = $clog2(result_depth) + 1;

    typedef logic signed [fv_size-1:0] feature_t;

    // one line of the feature stream.
    typedef struct packed {
        logic                         sos;
        logic                         eos;
        feature_t [fv_per_line-1:0]   features;
        logic [node_id_w-1:0]         node_id;
    } bank_line_t;

    typedef struct packed {
        feature_t [mult_per_pe-1:0]   features;
        logic [node_id_w-1:0]         node_id;
    } pe_slice_t;

    typedef pe_slice_t [num_pe-1:0] rs_out_t;

    typedef struct packed {
        logic [node_id_w-1:0]         node_id;
        logic signed [acc_w-1:0]      sum;
    } vertex_result_t;

    typedef feature_t [max_fv_num-1:0] weight_vec_t;

endpackage

/* hdl/gnn_apb_pkg.sv */
package gnn_apb_pkg;

    localparam int apb_addr_w       = 8;
    localparam int apb_data_w       = 32;
    localparam int num_weight_words = 4;
    localparam int weight_word_w    = $clog2(num_weight_words);
    localparam int weight_span      = num_weight_words * (apb_data_w / 8);
    localparam int status_occ_w     = 4;
    localparam int status_empty_bit = 4;

    localparam logic [apb_addr_w-1:0] weight_base = 8'h00;
    localparam logic [apb_addr_w-1:0] status_addr = 8'h10;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [apb_addr_w-1:0] paddr;
        logic [apb_data_w-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [apb_data_w-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

endpackage

/* hdl/vertex_rs.sv */
`timescale 1ns/1ps

module vertex_rs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  gnn_feature_pkg::bank_line_t          bank_in,
    input  logic [gnn_feature_pkg::fv_idx_w-1:0] start_idx,
    input  logic                                 complete,
    input  logic                                 buf_release,
    output gnn_feature_pkg::rs_out_t             rs_out,
    output logic                                 fire,
    output logic                                 rs_available,
    output logic                                 rs_empty
);
    import gnn_feature_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_receive,
        st_fire,
        st_wait_vertex,
        st_wait_buffer
    } rs_state_t;

    rs_state_t state;
    rs_state_t state_next;

    feature_t [num_pe-1:0][max_fv_num-1:0] fv_store;
    logic [node_id_w-1:0]                  id_store [num_pe];

    logic [slot_w-1:0] slot_ptr;
    logic [slot_w:0]   node_cnt;
    logic [line_w-1:0] line_idx;
    logic              line_load;
    logic              node_done;
    rs_out_t           rs_out_next;

    // a line is taken on sos in idle and on every cycle of receive.
    assign line_load = (state == st_idle && bank_in.sos) || state == st_receive;
    assign node_done = line_load && bank_in.eos;
    assign fire      = node_done && node_cnt == (slot_w + 1)'(num_pe - 1);
    assign rs_empty  = node_cnt == '0 && state == st_idle;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (bank_in.sos) begin
                    if (fire) begin
                        state_next = st_fire;
                    end else if (!bank_in.eos) begin
                        state_next = st_receive;
                    end
                end
            end
            st_receive: begin
                if (fire) begin
                    state_next = st_fire;
                end else if (bank_in.eos) begin
                    state_next = st_idle;
                end
            end
            st_fire:        state_next = st_wait_vertex;
            st_wait_vertex: state_next = complete ? st_wait_buffer : st_wait_vertex;
            st_wait_buffer: state_next = buf_release ? st_idle : st_wait_buffer;
            default:        state_next = st_idle;
        endcase
    end

    // chunk for all four slots, registered on the way out.
    always_comb begin
        rs_out_next = '0;
        if (state == st_fire || state == st_wait_vertex) begin
            for (int i = 0; i < num_pe; i++) begin
                rs_out_next[i].node_id = id_store[i];
                for (int j = 0; j < mult_per_pe; j++) begin
                    rs_out_next[i].features[j] = fv_store[i][start_idx + fv_idx_w'(j)];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= st_idle;
            slot_ptr     <= '0;
            node_cnt     <= '0;
            line_idx     <= '0;
            rs_available <= 1'b0;
            rs_out       <= '0;
        end else begin
            state        <= state_next;
            rs_available <= state_next == st_idle;
            rs_out       <= rs_out_next;
            if (state == st_wait_buffer && buf_release) begin
                slot_ptr <= '0;
                node_cnt <= '0;
                line_idx <= '0;
            end else if (line_load) begin
                line_idx <= bank_in.eos ? '0 : line_idx + 1'b1;
                if (bank_in.eos) begin
                    slot_ptr <= slot_ptr + 1'b1;
                    node_cnt <= node_cnt + 1'b1;
                end
            end
        end
    end

    // a new node clears its slot so short nodes read zeros past their last line.
    always_ff @(posedge clk) begin
        if (line_load) begin
            if (state == st_idle) begin
                fv_store[slot_ptr] <= '0;
                id_store[slot_ptr] <= bank_in.node_id;
            end
            for (int j = 0; j < fv_per_line; j++) begin
                fv_store[slot_ptr][line_idx * fv_per_line + j] <= bank_in.features[j];
            end
        end
    end

endmodule

/* hdl/vertex_pe.sv */
`timescale 1ns/1ps

module vertex_pe (
    input  logic                                clk,
    input  logic                                reset,
    input  gnn_feature_pkg::pe_slice_t          slice,
    input  gnn_feature_pkg::weight_vec_t        weights,
    input  logic [gnn_feature_pkg::chunk_w-1:0] chunk_sel,
    input  logic                                acc_clear,
    input  logic                                acc_en,
    output gnn_feature_pkg::vertex_result_t     result
);
    import gnn_feature_pkg::*;

    logic [chunk_w-1:0]         chunk_q;
    feature_t [mult_per_pe-1:0] wsel;
    logic signed [acc_w-1:0]    chunk_sum;
    logic signed [acc_w-1:0]    acc;
    logic [node_id_w-1:0]       id_q;

    // chunk_sel runs one cycle ahead of the registered slice.
    always_comb begin
        chunk_sum = '0;
        for (int j = 0; j < mult_per_pe; j++) begin
            wsel[j]   = weights[chunk_q * mult_per_pe + j];
            chunk_sum = chunk_sum + slice.features[j] * wsel[j];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chunk_q <= '0;
            acc     <= '0;
            id_q    <= '0;
        end else begin
            chunk_q <= chunk_sel;
            if (acc_clear) begin
                acc <= '0;
            end else if (acc_en) begin
                acc <= acc + chunk_sum;
                // node id rides along with the first chunk.
                if (chunk_q == '0) begin
                    id_q <= slice.node_id;
                end
            end
        end
    end

    assign result = '{node_id: id_q, sum: acc};

endmodule

/* hdl/vertex_ctrl.sv */
`timescale 1ns/1ps

module vertex_ctrl (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 fire,
    input  logic [gnn_feature_pkg::occ_w-1:0]    fifo_free,
    output logic [gnn_feature_pkg::fv_idx_w-1:0] start_idx,
    output logic                                 complete,
    output logic                                 acc_clear,
    output logic                                 acc_en,
    output logic                                 push,
    output logic                                 buf_release
);
    import gnn_feature_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain,
        st_push
    } ctrl_state_t;

    ctrl_state_t        state;
    logic [chunk_w-1:0] chunk_cnt;
    logic               last_chunk;
    logic               room;

    assign last_chunk  = chunk_cnt == chunk_w'(max_fv_num / mult_per_pe - 1);
    assign room        = fifo_free >= occ_w'(num_pe);
    assign start_idx   = (state == st_issue) ? fv_idx_w'(chunk_cnt * mult_per_pe) : '0;
    assign complete    = state == st_issue && last_chunk;
    assign acc_clear   = state == st_issue && chunk_cnt == '0;
    assign push        = state == st_push && room;
    assign buf_release = push;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            chunk_cnt <= '0;
            acc_en    <= 1'b0;
        end else begin
            // accumulate trails the index by the station's output register.
            acc_en <= state == st_issue;
            case (state)
                st_idle: begin
                    chunk_cnt <= '0;
                    if (fire) begin
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (last_chunk) begin
                        state <= st_drain;
                    end
                end
                st_drain: state <= st_push;
                st_push: begin
                    if (room) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* hdl/weight_regs.sv */
`timescale 1ns/1ps

module weight_regs (
    input  logic                              clk,
    input  logic                              reset,
    input  gnn_apb_pkg::apb_req_t             apb_req,
    input  logic [gnn_feature_pkg::occ_w-1:0] fifo_count,
    input  logic                              rs_empty,
    output gnn_apb_pkg::apb_rsp_t             apb_rsp,
    output gnn_feature_pkg::weight_vec_t      weights
);
    import gnn_apb_pkg::*;

    logic [num_weight_words-1:0][apb_data_w-1:0] weight_words;

    logic                     access;
    logic [apb_addr_w-1:0]    word_off;
    logic [weight_word_w-1:0] word_idx;
    logic                     weight_hit;
    logic                     status_hit;
    logic [apb_data_w-1:0]    status_word;

    assign access     = apb_req.psel && apb_req.penable;
    assign word_off   = apb_req.paddr - weight_base;
    assign word_idx   = word_off[weight_word_w+1:2];
    assign weight_hit = word_off < weight_span && word_off[1:0] == 2'b00;
    assign status_hit = apb_req.paddr == status_addr;
    assign weights    = weight_words;

    always_comb begin
        status_word = '0;
        status_word[status_occ_w-1:0] = fifo_count;
        status_word[status_empty_bit] = rs_empty;
    end

    // ==============================
    // response, completes in the enable cycle
    // ==============================
    always_comb begin
        apb_rsp        = '0;
        apb_rsp.pready = 1'b1;
        if (access) begin
            apb_rsp.pslverr = !(weight_hit || status_hit) || (status_hit && apb_req.pwrite);
            if (!apb_req.pwrite) begin
                if (weight_hit) begin
                    apb_rsp.prdata = weight_words[word_idx];
                end else if (status_hit) begin
                    apb_rsp.prdata = status_word;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            weight_words <= '0;
        end else if (access && apb_req.pwrite && weight_hit) begin
            weight_words[word_idx] <= apb_req.pwdata;
        end
    end

endmodule

/* hdl/vertex_result_fifo.sv */
`timescale 1ns/1ps

module vertex_result_fifo (
    input  logic                                                     clk,
    input  logic                                                     reset,
    input  logic                                                     push,
    input  gnn_feature_pkg::vertex_result_t [gnn_feature_pkg::num_pe-1:0] push_data,
    input  logic                                                     pop_ready,
    output logic                                                     pop_valid,
    output gnn_feature_pkg::vertex_result_t                          pop_data,
    output logic [gnn_feature_pkg::occ_w-1:0]                        free,
    output logic [gnn_feature_pkg::occ_w-1:0]                        count
);
    import gnn_feature_pkg::*;

    vertex_result_t          mem [result_depth];
    logic [result_ptr_w-1:0] wr_ptr;
    logic [result_ptr_w-1:0] rd_ptr;
    logic                    pop;

    assign pop_valid = count != '0;
    assign pop       = pop_valid && pop_ready;
    assign pop_data  = mem[rd_ptr];
    assign free      = occ_w'(result_depth) - count;

    // wide write, pe 0 lands first.
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < num_pe; i++) begin
                mem[wr_ptr + result_ptr_w'(i)] <= push_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + result_ptr_w'(num_pe);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (push ? occ_w'(num_pe) : occ_w'(0)) - (pop ? occ_w'(1) : occ_w'(0));
        end
    end

endmodule

/* hdl/vertex_unit.sv */
`timescale 1ns/1ps

module vertex_unit (
    input  logic                            clk,
    input  logic                            reset,
    input  gnn_feature_pkg::bank_line_t     bank_in,
    input  gnn_apb_pkg::apb_req_t           apb_req,
    input  logic                            result_ready,
    output logic                            rs_available,
    output gnn_apb_pkg::apb_rsp_t           apb_rsp,
    output logic                            result_valid,
    output gnn_feature_pkg::vertex_result_t result
);
    import gnn_feature_pkg::*;

    rs_out_t                     rs_out;
    weight_vec_t                 weights;
    vertex_result_t [num_pe-1:0] pe_result;
    logic [fv_idx_w-1:0]         start_idx;
    logic [occ_w-1:0]            fifo_free;
    logic [occ_w-1:0]            fifo_count;
    logic                        fire;
    logic                        complete;
    logic                        buf_release;
    logic                        acc_clear;
    logic                        acc_en;
    logic                        push;
    logic                        rs_empty;

    vertex_rs vertex_rs_i (
        .clk          (clk),
        .reset        (reset),
        .bank_in      (bank_in),
        .start_idx    (start_idx),
        .complete     (complete),
        .buf_release  (buf_release),
        .rs_out       (rs_out),
        .fire         (fire),
        .rs_available (rs_available),
        .rs_empty     (rs_empty)
    );

    vertex_ctrl vertex_ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .fire        (fire),
        .fifo_free   (fifo_free),
        .start_idx   (start_idx),
        .complete    (complete),
        .acc_clear   (acc_clear),
        .acc_en      (acc_en),
        .push        (push),
        .buf_release (buf_release)
    );

    for (genvar i = 0; i < num_pe; i++) begin : g_pe
        vertex_pe vertex_pe_i (
            .clk       (clk),
            .reset     (reset),
            .slice     (rs_out[i]),
            .weights   (weights),
            .chunk_sel (start_idx[fv_idx_w-1 -: chunk_w]),
            .acc_clear (acc_clear),
            .acc_en    (acc_en),
            .result    (pe_result[i])
        );
    end

    weight_regs weight_regs_i (
        .clk        (clk),
        .reset      (reset),
        .apb_req    (apb_req),
        .fifo_count (fifo_count),
        .rs_empty   (rs_empty),
        .apb_rsp    (apb_rsp),
        .weights    (weights)
    );

    vertex_result_fifo vertex_result_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_data (pe_result),
        .pop_ready (result_ready),
        .pop_valid (result_valid),
        .pop_data  (result),
        .free      (fifo_free),
        .count     (fifo_count)
    );

endmodule

/* testbench/vertex_unit_chk.sv */
`timescale 1ns/1ps

module vertex_unit_chk (
    input logic                              clk,
    input logic                              reset,
    input gnn_feature_pkg::bank_line_t       bank_in,
    input logic                              rs_available,
    input gnn_apb_pkg::apb_req_t             apb_req,
    input logic                              result_valid,
    input logic                              result_ready,
    input gnn_feature_pkg::vertex_result_t   result,
    input logic                              push,
    input logic [gnn_feature_pkg::occ_w-1:0] fifo_free
);
    import gnn_feature_pkg::*;

    logic [occ_w-1:0] occupancy;

    // buffer fill seen from the push strobe and the result handshake.
    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + (push ? occ_w'(num_pe) : occ_w'(0))
                         - ((result_valid && result_ready) ? occ_w'(1) : occ_w'(0));
        end
    end

    sos_when_available: assert property (@(posedge clk) disable iff (reset)
        bank_in.sos |-> rs_available)
        else $error("sos presented while the station is unavailable");

    // enable phase must follow a setup phase.
    penable_after_setup: assert property (@(posedge clk) disable iff (reset)
        apb_req.psel && apb_req.penable |-> $past(apb_req.psel) && !$past(apb_req.penable))
        else $error("APB penable without a setup cycle");

    result_stable: assert property (@(posedge clk) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result))
        else $error("result changed while valid and not ready");

    push_with_room: assert property (@(posedge clk) disable iff (reset)
        push |-> occupancy <= occ_w'(result_depth - num_pe))
        else $error("push with fewer than four free entries");

    free_count: assert property (@(posedge clk) disable iff (reset)
        fifo_free == occ_w'(result_depth) - occupancy)
        else $error("fifo free count disagrees with the pushes and pops seen");

endmodule

bind vertex_unit vertex_unit_chk vertex_unit_chk_i (
    .clk          (clk),
    .reset        (reset),
    .bank_in      (bank_in),
    .rs_available (rs_available),
    .apb_req      (apb_req),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result),
    .push         (push),
    .fifo_free    (fifo_free)
);

/* testbench/vertex_unit_tb.sv */
`timescale 1ns/1ps

module vertex_unit_tb;
    import gnn_feature_pkg::*;
    import gnn_apb_pkg::*;

    localparam int clk_period     = 20;
    localparam int timeout_cycles = 200;

    typedef feature_t [max_fv_num-1:0] node_fv_t;

    logic           clk;
    logic           reset;
    bank_line_t     bank_in;
    apb_req_t       apb_req;
    apb_rsp_t       apb_rsp;
    logic           result_ready;
    logic           rs_available;
    logic           result_valid;
    vertex_result_t result;

    integer                  seed;
    int                      errors = 0;
    int                      cycle_cnt = 0;
    int                      last_eos_cycle = 0;
    logic [31:0]             weight_words [num_weight_words];
    logic [node_id_w-1:0]    exp_id [$];
    logic signed [acc_w-1:0] exp_sum [$];

    vertex_unit vertex_unit_i (
        .clk          (clk),
        .reset        (reset),
        .bank_in      (bank_in),
        .apb_req      (apb_req),
        .result_ready (result_ready),
        .rs_available (rs_available),
        .apb_rsp      (apb_rsp),
        .result_valid (result_valid),
        .result       (result)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ==============================
    // helpers
    // ==============================
    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "stopped on a timeout");
    endtask

    function automatic logic [apb_addr_w-1:0] weight_addr(input int k);
        return weight_base + apb_addr_w'(k * 4);
    endfunction

    // two-phase transfer, entered and left 1 ns after a rising edge.
    task automatic apb_access(input logic write, input logic [apb_addr_w-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int waited;
        waited = 0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #2;
        while (!apb_rsp.pready) begin
            if (waited == timeout_cycles) begin
                report_timeout("APB pready");
            end
            waited++;
            @(posedge clk);
            #3;
        end
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [apb_addr_w-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        compare(32'(slverr), 32'(exp_err), $sformatf("pslverr on write to 0x%0h", addr));
    endtask

    task automatic read_reg(input logic [apb_addr_w-1:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b0, addr, 32'd0, rdata, slverr);
        compare(32'(slverr), 32'(exp_err), $sformatf("pslverr on read of 0x%0h", addr));
        compare(rdata, exp_data, $sformatf("read data at 0x%0h", addr));
    endtask

    // reference dot product over the weights written so far.
    function automatic logic signed [acc_w-1:0] dot_product(input node_fv_t fv);
        int       sum;
        feature_t w;
        sum = 0;
        for (int i = 0; i < max_fv_num; i++) begin
            w   = weight_words[i / 4][(i % 4) * 8 +: 8];
            sum = sum + int'(fv[i]) * int'(w);
        end
        return sum[acc_w-1:0];
    endfunction

    function automatic node_fv_t random_features();
        node_fv_t fv;
        for (int i = 0; i < max_fv_num; i++) begin
            fv[i] = feature_t'($random(seed));
        end
        return fv;
    endfunction

    task automatic wait_available();
        int waited;
        waited = 0;
        while (!rs_available) begin
            if (waited == timeout_cycles) begin
                report_timeout("rs_available");
            end
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_node(input logic [node_id_w-1:0] id, input node_fv_t fv,
                             input int num_lines);
        node_fv_t sent;
        sent = '0;
        wait_available();
        for (int l = 0; l < num_lines; l++) begin
            if (l > 0) begin
                compare(32'(rs_available), 32'd0, "rs_available while a node streams");
            end
            bank_in.sos     = l == 0;
            bank_in.eos     = l == num_lines - 1;
            bank_in.node_id = id;
            for (int j = 0; j < fv_per_line; j++) begin
                bank_in.features[j]        = fv[l * fv_per_line + j];
                sent[l * fv_per_line + j]  = fv[l * fv_per_line + j];
            end
            last_eos_cycle = cycle_cnt;
            @(posedge clk);
            #1;
        end
        bank_in = '0;
        exp_id.push_back(id);
        exp_sum.push_back(dot_product(sent));
    endtask

    // one node of the batch goes out as a single line.
    task automatic send_batch(input int short_slot);
        for (int n = 0; n < num_pe; n++) begin
            send_node(node_id_w'($random(seed)), random_features(), (n == short_slot) ? 1 : 4);
        end
    endtask

    task automatic collect_results(input int count);
        int waited;
        int got;
        waited = 0;
        got    = 0;
        result_ready = 1'b1;
        while (got < count) begin
            if (result_valid) begin
                if (exp_id.size() == 0) begin
                    $display("A result arrived at %0t ns with none expected", $time);
                    $display("Finished with errors");
                    $fatal(1, "stopped on an unexpected result");
                end
                compare(32'(result.node_id), 32'(exp_id.pop_front()), "result node id");
                compare(32'(result.sum), 32'(exp_sum.pop_front()), "result sum");
                got++;
                waited = 0;
            end else if (waited == timeout_cycles) begin
                report_timeout("result_valid");
            end else begin
                waited++;
            end
            @(posedge clk);
            #1;
        end
        result_ready = 1'b0;
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic check_reset_state();
        compare(32'(rs_available), 32'd1, "rs_available after reset");
        compare(32'(result_valid), 32'd0, "result_valid after reset");
        read_reg(status_addr, 32'h0000_0010, 1'b0);
    endtask

    task automatic check_weight_regs();
        for (int k = 0; k < num_weight_words; k++) begin
            weight_words[k] = $random(seed);
            write_reg(weight_addr(k), weight_words[k], 1'b0);
        end
        for (int k = 0; k < num_weight_words; k++) begin
            read_reg(weight_addr(k), weight_words[k], 1'b0);
        end
        write_reg(status_addr, 32'hdead_beef, 1'b1);
        write_reg(8'h20, 32'h1234_5678, 1'b1);
        read_reg(8'h20, 32'd0, 1'b1);
        read_reg(8'h06, 32'd0, 1'b1);
        for (int k = 0; k < num_weight_words; k++) begin
            read_reg(weight_addr(k), weight_words[k], 1'b0);
        end
    endtask

    task automatic run_dot_products();
        send_batch(2);
        collect_results(num_pe);
    endtask

    task automatic measure_latency();
        int waited;
        waited = 0;
        result_ready = 1'b1;
        send_batch(-1);
        while (!result_valid) begin
            compare(32'(rs_available), 32'd0, "rs_available while the station waits");
            if (waited == timeout_cycles) begin
                report_timeout("first result after fire");
            end
            waited++;
            @(posedge clk);
            #1;
        end
        compare(32'(cycle_cnt - last_eos_cycle), 32'd7, "fire to first result latency");
        collect_results(num_pe);
    endtask

    task automatic run_backpressure();
        result_ready = 1'b0;
        send_batch(0);
        send_batch(3);
        wait_available();
        read_reg(status_addr, 32'h0000_0018, 1'b0);
        send_batch(-1);
        // third batch is parked behind a full buffer.
        for (int c = 0; c < 20; c++) begin
            compare(32'(rs_available), 32'd0, "rs_available under back-pressure");
            compare(32'(result_valid), 32'd1, "result_valid under back-pressure");
            @(posedge clk);
            #1;
        end
        collect_results(3 * num_pe);
        wait_available();
        read_reg(status_addr, 32'h0000_0010, 1'b0);
    endtask

    initial begin
        seed         = 32'h4909_48ee;
        reset        = 1'b1;
        bank_in      = '0;
        apb_req      = '0;
        result_ready = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        compare(32'(rs_available), 32'd0, "rs_available in reset");
        compare(32'(result_valid), 32'd0, "result_valid in reset");
        compare(apb_rsp.prdata, 32'd0, "prdata in reset");
        compare(32'(apb_rsp.pslverr), 32'd0, "pslverr in reset");
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_reset_state();
        check_weight_regs();
        run_dot_products();
        measure_latency();
        run_backpressure();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* files.f */
hdl/gnn_feature_pkg.sv
hdl/gnn_apb_pkg.sv
hdl/vertex_rs.sv
hdl/vertex_pe.sv
hdl/vertex_ctrl.sv
hdl/weight_regs.sv
hdl/vertex_result_fifo.sv
hdl/vertex_unit.sv
testbench/vertex_unit_chk.sv
testbench/vertex_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vertex_unit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not complete"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
